// ==== bench/corePatterns.txt ====
# P byte-address word | R read-data | W address data sel
# T test-name write-count, followed by its W lines
P 00000000 800000B7
P 00000004 10000137
P 00000008 FF800193
P 0000000C 4011D213
P 00000010 0040A023
P 00000014 0041B2B3
P 00000018 0050A223
P 0000001C 00001317
P 00000020 0060A423
P 00000024 403203B3
P 00000028 0070A623
P 0000002C 87654437
P 00000030 3A140413
P 00000034 00812023
P 00000038 003102A3
P 0000003C 00311323
P 00000040 00010483
P 00000044 0090A823
P 00000048 00514503
P 0000004C 00A08AA3
P 00000050 00611583
P 00000054 00615603
P 00000058 00C09D23
P 0000005C 00B0AE23
P 00000060 00012683
P 00000064 02D0A023
P 00000068 00000463
P 0000006C 0200A223
P 00000070 00001463
P 00000074 0001C463
P 00000078 0200A223
P 0000007C 00307463
P 00000080 00C0076F
P 00000084 0200A223
P 00000088 0200A223
P 0000008C 02E0A223
P 00000090 018707E7
P 00000094 0200A223
P 00000098 0200A223
P 0000009C 02F0A423
P 000000A0 0400A803
P 000000A4 0440A883
P 000000A8 01180933
P 000000AC 0320A623
P 000000B0 04808983
P 000000B4 0330A823
P 000000B8 0E00AE23
P 000000BC 0000006F
R 12345678
R 11111111
R ABCDEFC5
T aluImm 4
W 80000000 FFFFFFFC F
W 80000004 00000001 F
W 80000008 0000101C F
W 8000000C 00000004 F
T memSizes 5
W 80000010 FFFFFFA1 F
W 80000015 0000F800 2
W 8000001A FFF80000 C
W 8000001C FFFFFFF8 F
W 80000020 876543A1 F
T controlFlow 2
W 80000024 00000084 F
W 80000028 00000094 F
T ioReads 2
W 8000002C 23456789 F
W 80000030 FFFFFFC5 F

// ==== filelist.f ====
common/rvPkg.sv
core/rvDecoder.sv
core/rvAlu.sv
core/rvRegFile.sv
core/rvCore.sv
src/instRam.sv
src/dataRam.sv
src/dataBusDecoder.sv
src/riscvSystem.sv
bench/riscvSystem_assertions.sv
bench/riscvSystemTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the riscvSystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module riscvSystemTb -f filelist.f -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
   exit 0
else
   echo "Pass message not found in $LOG"
   exit 1
fi

// ==== bench/riscvSystemTb.sv ====
`timescale 1ns/1ns

module riscvSystemTb import rvPkg::*; ();

   logic        clk;
   logic        rst;
   logic        stall;
   logic        progWe;
   logic [9:0]  progAddr;
   logic [31:0] progData;
   wbReqS       ioReq;
   wbRspS       ioRsp;

   logic [31:0]  progAddrQ [$];
   logic [31:0]  progWordQ [$];
   logic [31:0]  readQ [$];
   logic [31:0]  expAdrQ [$];
   logic [31:0]  expDatQ [$];
   logic [3:0]   expSelQ [$];
   logic [127:0] testNameQ [$];
   int           testCountQ [$];

   int          errors;
   int          testsPassed;
   int          testsFailed;
   int          testIdx;
   int          testWrites;
   int          testErrors;
   logic [31:0] rngState;
   bit          loaded;

   riscvSystem DUT (.clk(clk), .rst(rst), .stall(stall), .progWe(progWe),
                    .progAddr(progAddr), .progData(progData), .ioReq(ioReq), .ioRsp(ioRsp));

   always #10 clk = ~clk;

   function automatic logic [31:0] nextRandom();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   task automatic readPatterns(output bit opened);
      integer        fd;
      integer        code;
      logic [63:0]   tag;
      logic [1023:0] lineBuf;
      logic [31:0]   a;
      logic [31:0]   d;
      logic [3:0]    s;
      logic [127:0]  name;
      int            cnt;
      fd = $fopen("bench/corePatterns.txt", "r");
      opened = (fd != 0);
      if (opened)
      begin
         while (!$feof(fd))
         begin
            tag = '0;
            code = $fscanf(fd, "%s", tag);
            if (code != 1)
               continue;
            if (tag == "#")
               code = $fgets(lineBuf, fd);
            else if (tag == "P")
            begin
               code = $fscanf(fd, "%h %h", a, d);
               progAddrQ.push_back(a);
               progWordQ.push_back(d);
            end
            else if (tag == "R")
            begin
               code = $fscanf(fd, "%h", d);
               readQ.push_back(d);
            end
            else if (tag == "W")
            begin
               code = $fscanf(fd, "%h %h %h", a, d, s);
               expAdrQ.push_back(a);
               expDatQ.push_back(d);
               expSelQ.push_back(s);
            end
            else if (tag == "T")
            begin
               code = $fscanf(fd, "%s %d", name, cnt);
               testNameQ.push_back(name);
               testCountQ.push_back(cnt);
            end
         end
         $fclose(fd);
      end
   endtask

   // Samples the bus 2 ns after the edge, where the DUT outputs have settled
   task automatic waitRequest(output bit found);
      int cycles;
      found = 0;
      cycles = 0;
      while (!found && cycles < 5000)
      begin
         @(posedge clk);
         #2;
         cycles++;
         if (ioReq.cyc && ioReq.stb)
            found = 1;
      end
   endtask

   task automatic reportTest();
      if (testErrors == 0)
      begin
         $display("Test %0s: passed", testNameQ[testIdx]);
         testsPassed++;
      end
      else
      begin
         $display("Test %0s: failed with %0d errors", testNameQ[testIdx], testErrors);
         testsFailed++;
      end
      testIdx++;
      testWrites = 0;
      testErrors = 0;
   endtask

   task automatic checkWrite(input wbReqS req);
      if (expAdrQ.size() == 0)
      begin
         $display("Unexpected IO write to %h with data %h at %0t ns", req.adr, req.dat, $time);
         errors++;
      end
      else
      begin
         if (req.adr !== expAdrQ[0] || req.dat !== expDatQ[0] || req.sel !== expSelQ[0])
         begin
            $display("[FAIL] %0t ns: IO write %h data %h sel %h, expected %h data %h sel %h",
                     $time, req.adr, req.dat, req.sel, expAdrQ[0], expDatQ[0], expSelQ[0]);
            errors++;
            testErrors++;
         end
         void'(expAdrQ.pop_front());
         void'(expDatQ.pop_front());
         void'(expSelQ.pop_front());
         testWrites++;
         if (testIdx < testCountQ.size() && testWrites == testCountQ[testIdx])
            reportTest();
      end
   endtask

   // Acts as the IO slave with 0 to 3 wait cycles
   task automatic serveRequest(output bit endSeen);
      wbReqS req;
      int    waits;
      req = ioReq;
      endSeen = 0;
      waits = int'(nextRandom() % 4);
      repeat (waits)
      begin
         @(posedge clk);
         #2;
      end
      ioRsp.ack = 1'b1;
      ioRsp.dat = 32'h0;
      if (!req.we)
      begin
         if (readQ.size() == 0)
         begin
            $display("IO read from %h with no read data left at %0t ns", req.adr, $time);
            errors++;
         end
         else
            ioRsp.dat = readQ.pop_front();
      end
      @(posedge clk);
      #2;
      ioRsp.ack = 1'b0;
      if (req.we)
      begin
         if (req.adr == 32'h8000_00FC)
            endSeen = 1;
         else
            checkWrite(req);
      end
   endtask

   // Reset, program load, then the IO slave until the end marker
   task automatic runProgram();
      bit found;
      bit endSeen;
      bit stopped;
      int requests;
      endSeen = 0;
      stopped = 0;
      requests = 0;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      // Program load while the core is frozen
      foreach (progAddrQ[i])
      begin
         @(posedge clk);
         #2;
         progWe = 1'b1;
         progAddr = progAddrQ[i][11:2];
         progData = progWordQ[i];
      end
      @(posedge clk);
      #2;
      progWe = 1'b0;
      stall = 1'b0;
      while (!endSeen && !stopped)
      begin
         waitRequest(found);
         if (!found)
         begin
            $display("Timeout while waiting for an IO bus request");
            errors++;
            stopped = 1;
         end
         // Far more accesses than the program makes
         else if (requests == 200)
         begin
            $display("Too many IO bus requests without the end marker");
            errors++;
            stopped = 1;
         end
         else
         begin
            serveRequest(endSeen);
            requests++;
         end
      end
      if (expAdrQ.size() != 0)
      begin
         $display("Run ended with %0d expected IO writes missing", expAdrQ.size());
         errors++;
      end
      if (readQ.size() != 0)
      begin
         $display("Run ended with %0d IO read responses never requested", readQ.size());
         errors++;
      end
   endtask

   initial
   begin
      clk = 1'b0;
      rst = 1'b1;
      stall = 1'b1;
      progWe = 1'b0;
      progAddr = '0;
      progData = '0;
      ioRsp = '0;
      errors = 0;
      testsPassed = 0;
      testsFailed = 0;
      testIdx = 0;
      testWrites = 0;
      testErrors = 0;
      rngState = 32'he06a58d1;
      readPatterns(loaded);
      if (!loaded)
      begin
         $display("Cannot open bench/corePatterns.txt");
         errors++;
      end
      else
         runProgram();
      if (DUT.ioChecks.failures != 0)
      begin
         $display("%0d IO bus protocol assertions failed", DUT.ioChecks.failures);
         errors += DUT.ioChecks.failures;
      end
      while (testIdx < testCountQ.size())
      begin
         testErrors++;
         reportTest();
      end
      $display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== bench/riscvSystem_assertions.sv ====
`timescale 1ns/1ns

module riscvSystem_assertions import rvPkg::*; (
   input        clk,
   input        rst,
   input wbReqS ioReq,
   input wbRspS ioRsp
);

   // Failed property count
   int failures = 0;

   stbNeedsCyc: assert property (@(posedge clk) disable iff (rst) ioReq.stb |-> ioReq.cyc)
      else
      begin
         $error("IO stb without cyc");
         failures++;
      end

   // Request held until the slave answers
   reqStable: assert property (@(posedge clk) disable iff (rst)
      ioReq.stb && !ioRsp.ack |=> $stable(ioReq))
      else
      begin
         $error("IO request changed before ack");
         failures++;
      end

   idleAfterReset: assert property (@(posedge clk) rst |=> !ioReq.cyc)
      else
      begin
         $error("IO cyc high after reset");
         failures++;
      end

   ackNeedsStb: assert property (@(posedge clk) disable iff (rst) ioRsp.ack |-> ioReq.stb)
      else
      begin
         $error("IO ack without stb");
         failures++;
      end

endmodule

bind riscvSystem riscvSystem_assertions ioChecks (.clk(clk), .rst(rst), .ioReq(ioReq),
                                                  .ioRsp(ioRsp));

// ==== src/riscvSystem.sv ====
`timescale 1ns/1ns

module riscvSystem import rvPkg::*; (
   input               clk,
   input               rst,
   input               stall,
   input               progWe,
   input  logic [9:0]  progAddr,
   input  logic [31:0] progData,
   output wbReqS       ioReq,
   input  wbRspS       ioRsp
);

   logic [9:0]  fetchAddr;
   logic        fetchEn;
   logic [31:0] fetchData;
   wbReqS       coreReq;
   wbRspS       coreRsp;
   wbReqS       ramReq;
   wbRspS       ramRsp;

   rvCore core (.clk(clk), .rst(rst), .stall(stall), .fetchAddr(fetchAddr),
                .fetchEn(fetchEn), .fetchData(fetchData), .dataReq(coreReq),
                .dataRsp(coreRsp));

   instRam iram (.clk(clk), .progWe(progWe), .progAddr(progAddr), .progData(progData),
                 .fetchEn(fetchEn), .fetchAddr(fetchAddr), .fetchData(fetchData));

   dataBusDecoder busDecoder (.clk(clk), .rst(rst), .coreReq(coreReq), .coreRsp(coreRsp),
                              .ramReq(ramReq), .ioReq(ioReq), .ramRsp(ramRsp),
                              .ioRsp(ioRsp));

   dataRam dram (.clk(clk), .rst(rst), .req(ramReq), .rsp(ramRsp));

endmodule

// ==== src/dataBusDecoder.sv ====
`timescale 1ns/1ns

module dataBusDecoder import rvPkg::*; (
   input         clk,
   input         rst,
   input  wbReqS coreReq,
   output wbRspS coreRsp,
   output wbReqS ramReq,
   output wbReqS ioReq,
   input  wbRspS ramRsp,
   input  wbRspS ioRsp
);

   logic ramSel;
   logic ioSel;
   logic errAck;

   assign ramSel = coreReq.adr[31:28] == ramRegion;
   assign ioSel = coreReq.adr[31:28] == ioRegion;

   always_comb
   begin
      ramReq = coreReq;
      ramReq.cyc = coreReq.cyc && ramSel;
      ramReq.stb = coreReq.stb && ramSel;
      ioReq = coreReq;
      ioReq.cyc = coreReq.cyc && ioSel;
      ioReq.stb = coreReq.stb && ioSel;
   end

   // Unmapped region answers itself, one cycle later
   always_ff @(posedge clk)
   begin
      if (rst)
         errAck <= 1'b0;
      else
         errAck <= coreReq.cyc && coreReq.stb && !ramSel && !ioSel && !errAck;
   end

   assign coreRsp = ramSel ? ramRsp : (ioSel ? ioRsp : '{ack: errAck, dat: 32'h0});

endmodule

// ==== src/dataRam.sv ====
`timescale 1ns/1ns

module dataRam import rvPkg::*; (
   input         clk,
   input         rst,
   input  wbReqS req,
   output wbRspS rsp
);

   logic [31:0]                  mem [dataWords];
   logic [$clog2(dataWords)-1:0] wordAddr;
   logic                         access;
   logic                         ack;
   logic [31:0]                  rdData;

   assign wordAddr = req.adr[$clog2(dataWords)+1:2];

   // Acting once per transfer, not again in the ack cycle
   assign access = req.cyc && req.stb && !ack;

   always_ff @(posedge clk)
   begin
      if (rst)
         ack <= 1'b0;
      else
         ack <= access;
   end

   always_ff @(posedge clk)
   begin
      if (access && req.we)
      begin
         for (int lane = 0; lane < 4; lane++)
         begin
            if (req.sel[lane])
               mem[wordAddr][lane*8 +: 8] <= req.dat[lane*8 +: 8];
         end
      end
      rdData <= mem[wordAddr];
   end

   assign rsp.ack = ack;
   assign rsp.dat = rdData;

endmodule

// ==== src/instRam.sv ====
`timescale 1ns/1ns

module instRam import rvPkg::*; (
   input               clk,
   input               progWe,
   input  logic [9:0]  progAddr,
   input  logic [31:0] progData,
   input               fetchEn,
   input  logic [9:0]  fetchAddr,
   output logic [31:0] fetchData
);

   logic [31:0] mem [instWords];

   // Load port
   always_ff @(posedge clk)
   begin
      if (progWe)
         mem[progAddr] <= progData;
   end

   // Fetch port holds its output while disabled
   always_ff @(posedge clk)
   begin
      if (fetchEn)
         fetchData <= mem[fetchAddr];
   end

endmodule

// ==== core/rvCore.sv ====
`timescale 1ns/1ns

module rvCore import rvPkg::*; (
   input               clk,
   input               rst,
   input               stall,
   output logic [9:0]  fetchAddr,
   output logic        fetchEn,
   input  logic [31:0] fetchData,
   output wbReqS       dataReq,
   input  wbRspS       dataRsp
);

   logic [31:0] pc;
   logic [31:0] exPc;
   logic        exBubble;
   instrU       exInstr;
   ctrlS        ctrl;
   logic [31:0] imm;
   logic [31:0] rd1, rd2;
   logic [31:0] rs1Val, rs2Val;
   logic [31:0] aluA, aluB, aluResult;
   logic        branchCond, redirect;
   logic [31:0] targetPc;
   logic        exAccess, reqOn, accessDone, memWait, advance;
   logic        busy, gap, ackPend;
   logic [31:0] heldData, loadRaw;
   logic        wbRegWrite;
   logic [4:0]  wbRd;
   logic [1:0]  wbSel;
   logic [2:0]  wbFunct3;
   logic [1:0]  wbByteOff;
   logic [31:0] wbAlu, wbLink, wbLoadWord;
   logic [31:0] loadShifted, loadValue, wbValue;

   assign exInstr = exBubble ? nopInstr : fetchData;

   rvDecoder decoder (.instr(exInstr), .ctrl(ctrl), .imm(imm));

   rvRegFile regFile (.clk(clk), .we(wbRegWrite), .ra1(exInstr.r.rs1), .ra2(exInstr.r.rs2),
                      .wa(wbRd), .wd(wbValue), .rd1(rd1), .rd2(rd2));

   // Forward from writeback
   assign rs1Val = (wbRegWrite && wbRd != 5'd0 && wbRd == exInstr.r.rs1) ? wbValue : rd1;
   assign rs2Val = (wbRegWrite && wbRd != 5'd0 && wbRd == exInstr.r.rs2) ? wbValue : rd2;

   assign aluA = ctrl.srcAPc ? exPc : (ctrl.srcAZero ? 32'h0 : rs1Val);
   assign aluB = ctrl.srcBImm ? imm : rs2Val;

   rvAlu alu (.a(aluA), .b(aluB), .op(ctrl.aluOp), .result(aluResult));

   // funct3[0] inverts the condition (BNE, BGE, BGEU)
   assign branchCond = ctrl.funct3[2] ? aluResult[0] : (aluResult == 32'h0);
   assign redirect = (ctrl.isBranch && (branchCond ^ ctrl.funct3[0])) || ctrl.isJal || ctrl.isJalr;
   assign targetPc = ctrl.isJalr ? {aluResult[31:1], 1'b0} : exPc + imm;

   // Bus handshake; an ack seen under stall is parked in ackPend
   assign exAccess = ctrl.isLoad || ctrl.isStore;
   assign reqOn = exAccess && !gap && !ackPend && (!stall || busy);
   assign accessDone = dataRsp.ack || ackPend;
   assign memWait = exAccess && !accessDone;
   assign advance = !stall && !memWait;
   assign loadRaw = ackPend ? heldData : dataRsp.dat;

   assign fetchAddr = pc[11:2];
   assign fetchEn = advance;

   assign dataReq.cyc = reqOn;
   assign dataReq.stb = reqOn;
   assign dataReq.we = ctrl.isStore;
   assign dataReq.adr = aluResult;
   assign dataReq.dat = rs2Val << {aluResult[1:0], 3'b000};

   always_comb
   begin
      case (ctrl.funct3[1:0])
         2'b00: dataReq.sel = 4'b0001 << aluResult[1:0];
         2'b01: dataReq.sel = 4'b0011 << aluResult[1:0];
         default: dataReq.sel = 4'b1111;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc <= resetPc;
         exBubble <= 1'b1;
         wbRegWrite <= 1'b0;
         busy <= 1'b0;
         gap <= 1'b0;
         ackPend <= 1'b0;
      end
      else
      begin
         busy <= reqOn && !dataRsp.ack;
         gap <= dataRsp.ack;
         if (advance)
            ackPend <= 1'b0;
         else if (dataRsp.ack)
            ackPend <= 1'b1;
         if (advance)
         begin
            pc <= redirect ? targetPc : pc + 32'd4;
            exBubble <= redirect;
            wbRegWrite <= ctrl.regWrite;
         end
         else if (!stall)
            wbRegWrite <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (dataRsp.ack && !advance)
         heldData <= dataRsp.dat;
      if (advance)
      begin
         exPc <= pc;
         wbRd <= exInstr.r.rd;
         wbSel <= ctrl.wbSel;
         wbFunct3 <= ctrl.funct3;
         wbByteOff <= aluResult[1:0];
         wbAlu <= aluResult;
         wbLink <= exPc + 32'd4;
         wbLoadWord <= loadRaw;
      end
   end

   // Load alignment and extension
   assign loadShifted = wbLoadWord >> {wbByteOff, 3'b000};

   always_comb
   begin
      case (wbFunct3)
         3'b000: loadValue = {{24{loadShifted[7]}}, loadShifted[7:0]};
         3'b001: loadValue = {{16{loadShifted[15]}}, loadShifted[15:0]};
         3'b100: loadValue = {24'h0, loadShifted[7:0]};
         3'b101: loadValue = {16'h0, loadShifted[15:0]};
         default: loadValue = loadShifted;
      endcase
      case (wbSel)
         wbSelMem: wbValue = loadValue;
         wbSelLink: wbValue = wbLink;
         default: wbValue = wbAlu;
      endcase
   end

endmodule

// ==== core/rvRegFile.sv ====
`timescale 1ns/1ns

module rvRegFile (
   input               clk,
   input               we,
   input  logic [4:0]  ra1,
   input  logic [4:0]  ra2,
   input  logic [4:0]  wa,
   input  logic [31:0] wd,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);

   // x0 has no storage
   logic [31:0] regs [1:31];

   always_ff @(posedge clk)
   begin
      if (we && wa != 5'd0)
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == 5'd0) ? 32'h0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? 32'h0 : regs[ra2];

endmodule

// ==== core/rvAlu.sv ====
`timescale 1ns/1ns

module rvAlu import rvPkg::*; (
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  logic [3:0]  op,
   output logic [31:0] result
);

   logic [4:0] shamt;
   logic       lessSigned;
   logic       lessUnsigned;

   assign shamt = b[4:0];
   assign lessSigned = $signed(a) < $signed(b);
   assign lessUnsigned = a < b;

   always_comb
   begin
      case (op)
         aluAdd: result = a + b;
         aluSub: result = a - b;
         aluSll: result = a << shamt;
         aluSlt: result = {31'b0, lessSigned};
         aluSltu: result = {31'b0, lessUnsigned};
         aluXor: result = a ^ b;
         aluSrl: result = a >> shamt;
         aluSra: result = $unsigned($signed(a) >>> shamt);
         aluOr: result = a | b;
         aluAnd: result = a & b;
         aluPassB: result = b;
         default: result = a + b;
      endcase
   end

endmodule

// ==== core/rvDecoder.sv ====
`timescale 1ns/1ns

module rvDecoder import rvPkg::*; (
   input  instrU       instr,
   output ctrlS        ctrl,
   output logic [31:0] imm
);

   logic [31:0] iImm;
   logic [31:0] sImm;
   logic [31:0] bImm;
   logic [31:0] uImm;
   logic [31:0] jImm;
   logic [3:0]  funcAluOp;
   logic [3:0]  branchAluOp;

   // Sign-extended immediates, one per format view
   assign iImm = {{20{instr.i.imm[11]}}, instr.i.imm};
   assign sImm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
   assign bImm = {{19{instr.b.immBit12}}, instr.b.immBit12, instr.b.immBit11,
                  instr.b.immHi, instr.b.immLo, 1'b0};
   assign uImm = {instr.u.imm, 12'h000};
   assign jImm = {{11{instr.j.immBit20}}, instr.j.immBit20, instr.j.immHi,
                  instr.j.immBit11, instr.j.immLo, 1'b0};

   // SUB only exists for register operands, SRAI shares funct7 bit 5
   always_comb
   begin
      case (instr.r.funct3)
         3'b000: funcAluOp = (instr.r.opcode == opReg && instr.r.funct7[5]) ? aluSub : aluAdd;
         3'b001: funcAluOp = aluSll;
         3'b010: funcAluOp = aluSlt;
         3'b011: funcAluOp = aluSltu;
         3'b100: funcAluOp = aluXor;
         3'b101: funcAluOp = instr.r.funct7[5] ? aluSra : aluSrl;
         3'b110: funcAluOp = aluOr;
         default: funcAluOp = aluAnd;
      endcase
   end

   // BEQ/BNE compare by subtraction, the rest by set-less-than
   assign branchAluOp = instr.r.funct3[2] ? (instr.r.funct3[1] ? aluSltu : aluSlt) : aluSub;

   always_comb
   begin
      ctrl = '0;
      ctrl.aluOp = aluAdd;
      ctrl.wbSel = wbSelAlu;
      ctrl.funct3 = instr.r.funct3;
      imm = '0;
      case (instr.r.opcode)
         opLui:
         begin
            ctrl.srcAZero = 1'b1;
            ctrl.srcBImm = 1'b1;
            ctrl.regWrite = 1'b1;
            imm = uImm;
         end
         opAuipc:
         begin
            ctrl.srcAPc = 1'b1;
            ctrl.srcBImm = 1'b1;
            ctrl.regWrite = 1'b1;
            imm = uImm;
         end
         opJal:
         begin
            ctrl.srcAPc = 1'b1;
            ctrl.srcBImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.isJal = 1'b1;
            ctrl.wbSel = wbSelLink;
            imm = jImm;
         end
         opJalr:
         begin
            ctrl.srcBImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.isJalr = 1'b1;
            ctrl.wbSel = wbSelLink;
            imm = iImm;
         end
         opBranch:
         begin
            ctrl.aluOp = branchAluOp;
            ctrl.isBranch = 1'b1;
            imm = bImm;
         end
         opLoad:
         begin
            ctrl.srcBImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.isLoad = 1'b1;
            ctrl.wbSel = wbSelMem;
            imm = iImm;
         end
         opStore:
         begin
            ctrl.srcBImm = 1'b1;
            ctrl.isStore = 1'b1;
            imm = sImm;
         end
         opImm:
         begin
            ctrl.aluOp = funcAluOp;
            ctrl.srcBImm = 1'b1;
            ctrl.regWrite = 1'b1;
            imm = iImm;
         end
         opReg:
         begin
            ctrl.aluOp = funcAluOp;
            ctrl.regWrite = 1'b1;
         end
         default:
         begin
            // Unsupported opcode behaves as a NOP
            ctrl.funct3 = 3'b000;
         end
      endcase
   end

endmodule

// ==== common/rvPkg.sv ====
package rvPkg;

   // Memory sizes in 32-bit words
   localparam int instWords = 1024;
   localparam int dataWords = 1024;

   localparam logic [31:0] resetPc = 32'h0000_0000;

   // Top address nibble of each data region
   localparam logic [3:0] ramRegion = 4'h1;
   localparam logic [3:0] ioRegion = 4'h8;

   // ADDI x0, x0, 0
   localparam logic [31:0] nopInstr = 32'h0000_0013;

   localparam logic [6:0] opLui = 7'b0110111;
   localparam logic [6:0] opAuipc = 7'b0010111;
   localparam logic [6:0] opJal = 7'b1101111;
   localparam logic [6:0] opJalr = 7'b1100111;
   localparam logic [6:0] opBranch = 7'b1100011;
   localparam logic [6:0] opLoad = 7'b0000011;
   localparam logic [6:0] opStore = 7'b0100011;
   localparam logic [6:0] opImm = 7'b0010011;
   localparam logic [6:0] opReg = 7'b0110011;

   localparam logic [3:0] aluAdd = 4'd0;
   localparam logic [3:0] aluSub = 4'd1;
   localparam logic [3:0] aluSll = 4'd2;
   localparam logic [3:0] aluSlt = 4'd3;
   localparam logic [3:0] aluSltu = 4'd4;
   localparam logic [3:0] aluXor = 4'd5;
   localparam logic [3:0] aluSrl = 4'd6;
   localparam logic [3:0] aluSra = 4'd7;
   localparam logic [3:0] aluOr = 4'd8;
   localparam logic [3:0] aluAnd = 4'd9;
   localparam logic [3:0] aluPassB = 4'd10;

   // Register write source
   localparam logic [1:0] wbSelAlu = 2'd0;
   localparam logic [1:0] wbSelMem = 2'd1;
   localparam logic [1:0] wbSelLink = 2'd2;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [31:0] adr;
      logic [3:0]  sel;
      logic [31:0] dat;
   } wbReqS;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wbRspS;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rTypeS;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iTypeS;

   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sTypeS;

   // Immediate bits 12, 10:5, 4:1 and 11
   typedef struct packed {
      logic       immBit12;
      logic [5:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] immLo;
      logic       immBit11;
      logic [6:0] opcode;
   } bTypeS;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } uTypeS;

   // Immediate bits 20, 10:1, 11 and 19:12
   typedef struct packed {
      logic       immBit20;
      logic [9:0] immLo;
      logic       immBit11;
      logic [7:0] immHi;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jTypeS;

   typedef union packed {
      rTypeS r;
      iTypeS i;
      sTypeS s;
      bTypeS b;
      uTypeS u;
      jTypeS j;
   } instrU;

   typedef struct packed {
      logic [3:0] aluOp;
      logic       srcAPc;
      logic       srcAZero;
      logic       srcBImm;
      logic       regWrite;
      logic       isLoad;
      logic       isStore;
      logic       isBranch;
      logic       isJal;
      logic       isJalr;
      logic [1:0] wbSel;
      logic [2:0] funct3;
   } ctrlS;

endpackage
